// ==== dcore_settings.svh ====
`ifndef DCORE_SETTINGS_SVH
`define DCORE_SETTINGS_SVH

// number of time-interleaved ADC slices
`define DCORE_NTI 16

// ADC magnitude width, also the width of an unfolded code
`define DCORE_NADC 8

// PRBS7, x^7 + x^6 + 1
`define DCORE_PRBS_ORDER 7

// taps counted in serial positions back from the current bit
`define DCORE_PRBS_TAP_A 7
`define DCORE_PRBS_TAP_B 6

// width of the error and total bit counters
`define DCORE_CNT_W 32

`endif

// ==== dcore_pkg.sv ====
`default_nettype none

`include "dcore_settings.svh"

package dcore_pkg;

    // one slice as delivered by the analog side
    typedef struct packed {
        logic [`DCORE_NADC-1:0] mag;
        logic                   sign;
    } adc_sample_t;

    // all slices of one clk_adc cycle, slice k is serial position k
    typedef adc_sample_t [`DCORE_NTI-1:0] adc_word_t;

    // signed code after unfolding and offset removal
    typedef logic signed [`DCORE_NADC-1:0] code_t;
    typedef code_t [`DCORE_NTI-1:0] code_word_t;
    typedef code_t [`DCORE_NTI-1:0] offset_word_t;

    typedef enum logic [1:0] {
        MODE_CLEAR  = 2'd0,
        MODE_COUNT  = 2'd1,
        MODE_FREEZE = 2'd2
    } checker_mode_e;

    typedef struct packed {
        logic                  cke;
        logic [`DCORE_NTI-1:0] chan_sel;
        checker_mode_e         mode;
    } prbs_cfg_t;

    typedef struct packed {
        logic [`DCORE_CNT_W-1:0] err_count;
        logic [`DCORE_CNT_W-1:0] total_count;
    } prbs_counts_t;

endpackage

`default_nettype wire

// ==== adc_unfold.sv ====
`default_nettype none

`include "dcore_settings.svh"

module adc_unfold (
    input  wire logic                    clk_adc,
    input  wire logic                    reset_i,
    input  wire dcore_pkg::adc_word_t    adc_i,
    input  wire dcore_pkg::offset_word_t offset_i,
    output dcore_pkg::code_word_t        codes_o
);

    // two extra bits hold -255-127 .. 255+128 without wrap
    logic signed [`DCORE_NADC+1:0] exact [`DCORE_NTI];
    dcore_pkg::code_word_t         sat;

    always_comb begin
        for (int k = 0; k < `DCORE_NTI; k++) begin
            // sign 1 means a positive sample
            if (adc_i[k].sign) begin
                exact[k] = $signed({2'b00, adc_i[k].mag}) - offset_i[k];
            end else begin
                exact[k] = -$signed({2'b00, adc_i[k].mag}) - offset_i[k];
            end

            // top three bits equal means the value fits in NADC bits
            if ((&exact[k][`DCORE_NADC+1:`DCORE_NADC-1]) ||
                (~|exact[k][`DCORE_NADC+1:`DCORE_NADC-1])) begin
                sat[k] = exact[k][`DCORE_NADC-1:0];
            end else if (exact[k][`DCORE_NADC+1]) begin
                sat[k] = {1'b1, {(`DCORE_NADC-1){1'b0}}};
            end else begin
                sat[k] = {1'b0, {(`DCORE_NADC-1){1'b1}}};
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            codes_o <= '0;
        end else begin
            codes_o <= sat;
        end
    end

    // the most negative code only comes from a true negative overflow or an exact hit
    for (genvar k = 0; k < `DCORE_NTI; k++) begin : g_sat_check
        a_min_code: assert property (
            @(posedge clk_adc) disable iff (reset_i)
            (codes_o[k] == {1'b1, {(`DCORE_NADC-1){1'b0}}})
                |-> ($past(exact[k]) <= -(2 ** (`DCORE_NADC - 1)))
        );
    end

endmodule

`default_nettype wire

// ==== rx_decision.sv ====
`default_nettype none

`include "dcore_settings.svh"

module rx_decision (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    // unfolded codes from the ADC side
    input  wire dcore_pkg::code_word_t codes_i,
    input  wire dcore_pkg::code_t      thresh_i,
    // BIST source select
    input  wire logic                  sel_bist_i,
    input  wire logic [`DCORE_NTI-1:0] bist_word_i,
    output logic [`DCORE_NTI-1:0]      rx_bits_o
);

    logic [`DCORE_NTI-1:0] sliced;
    logic [`DCORE_NTI-1:0] chosen;

    // strict compare, a code equal to the threshold is a zero
    always_comb begin
        for (int k = 0; k < `DCORE_NTI; k++) begin
            sliced[k] = (codes_i[k] > thresh_i);
        end
    end

    assign chosen = sel_bist_i ? bist_word_i : sliced;

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            rx_bits_o <= '0;
        end else begin
            rx_bits_o <= chosen;
        end
    end

endmodule

`default_nettype wire

// ==== prbs_gen.sv ====
`default_nettype none

`include "dcore_settings.svh"

module prbs_gen (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    input  wire logic                  cke_i,
    input  wire logic                  inj_err_i,
    output logic [`DCORE_NTI-1:0]      word_o
);

    // state[0] is the newest serial bit, state[i] is i+1 positions back
    logic [`DCORE_PRBS_ORDER-1:0] state;
    logic [`DCORE_PRBS_ORDER-1:0] state_next;
    logic [`DCORE_NTI-1:0]        seq_bits;

    // LFSR unrolled over one word, bit 0 comes out first
    always_comb begin
        state_next = state;
        for (int k = 0; k < `DCORE_NTI; k++) begin
            seq_bits[k] = state_next[`DCORE_PRBS_TAP_A-1] ^ state_next[`DCORE_PRBS_TAP_B-1];
            state_next  = {state_next[`DCORE_PRBS_ORDER-2:0], seq_bits[k]};
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            state <= '1;
        end else if (cke_i) begin
            state <= state_next;
        end
    end

    // injected error flips the first bit of the word, state is untouched
    assign word_o = seq_bits ^ {{(`DCORE_NTI-1){1'b0}}, inj_err_i & cke_i};

endmodule

`default_nettype wire

// ==== prbs_checker.sv ====
`default_nettype none

`include "dcore_settings.svh"

module prbs_checker (
    input  wire logic                  clk_adc,
    input  wire logic                  reset_i,
    input  wire dcore_pkg::prbs_cfg_t  cfg_i,
    input  wire logic [`DCORE_NTI-1:0] rx_bits_i,
    output dcore_pkg::prbs_counts_t    counts_o
);

    // hist[ORDER-1] is the bit just before rx_bits_i[0]
    logic [`DCORE_PRBS_ORDER-1:0]           hist;
    logic [`DCORE_NTI+`DCORE_PRBS_ORDER-1:0] stream;
    logic [`DCORE_NTI-1:0]                   err_bits;

    function automatic logic [`DCORE_CNT_W-1:0] popcount(input logic [`DCORE_NTI-1:0] v);
        logic [`DCORE_CNT_W-1:0] n;
        n = '0;
        for (int i = 0; i < `DCORE_NTI; i++) begin
            n = n + {{(`DCORE_CNT_W-1){1'b0}}, v[i]};
        end
        return n;
    endfunction

    assign stream = {rx_bits_i, hist};

    // self-synchronizing check against the received bits themselves
    always_comb begin
        for (int k = 0; k < `DCORE_NTI; k++) begin
            err_bits[k] = stream[`DCORE_PRBS_ORDER + k]
                        ^ stream[`DCORE_PRBS_ORDER + k - `DCORE_PRBS_TAP_A]
                        ^ stream[`DCORE_PRBS_ORDER + k - `DCORE_PRBS_TAP_B];
        end
    end

    // history follows the line in every mode
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            hist <= '0;
        end else begin
            hist <= rx_bits_i[`DCORE_NTI-1 -: `DCORE_PRBS_ORDER];
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            counts_o <= '0;
        end else begin
            case (cfg_i.mode)
                dcore_pkg::MODE_CLEAR: begin
                    counts_o <= '0;
                end
                dcore_pkg::MODE_COUNT: begin
                    if (cfg_i.cke) begin
                        counts_o.total_count <= counts_o.total_count
                                              + popcount(cfg_i.chan_sel);
                        counts_o.err_count   <= counts_o.err_count
                                              + popcount(err_bits & cfg_i.chan_sel);
                    end
                end
                // freeze and the spare code hold
                default: begin
                    counts_o <= counts_o;
                end
            endcase
        end
    end

    a_freeze_hold: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        (cfg_i.mode == dcore_pkg::MODE_FREEZE) |=> $stable(counts_o)
    );

    // every error is also counted as a checked bit
    a_err_le_total: assert property (
        @(posedge clk_adc) disable iff (reset_i)
        counts_o.err_count <= counts_o.total_count
    );

endmodule

`default_nettype wire

// ==== dcore_top.sv ====
`default_nettype none

`include "dcore_settings.svh"

module dcore_top (
    input  wire logic                    clk_adc,
    input  wire logic                    reset_i,
    // ADC side
    input  wire dcore_pkg::adc_word_t    adc_i,
    input  wire dcore_pkg::offset_word_t offset_i,
    // decision and BIST controls
    input  wire dcore_pkg::code_t        thresh_i,
    input  wire logic                    sel_bist_i,
    input  wire logic                    gen_cke_i,
    input  wire logic                    gen_inj_err_i,
    input  wire dcore_pkg::prbs_cfg_t    prbs_cfg_i,
    // results
    output wire logic [`DCORE_NTI-1:0]   bits_o,
    output wire dcore_pkg::prbs_counts_t counts_o
);

    wire dcore_pkg::code_word_t codes;
    wire logic [`DCORE_NTI-1:0] bist_word;
    wire logic [`DCORE_NTI-1:0] rx_bits;

    adc_unfold u_unfold (
        .clk_adc  (clk_adc),
        .reset_i  (reset_i),
        .adc_i    (adc_i),
        .offset_i (offset_i),
        .codes_o  (codes)
    );

    prbs_gen u_gen (
        .clk_adc   (clk_adc),
        .reset_i   (reset_i),
        .cke_i     (gen_cke_i),
        .inj_err_i (gen_inj_err_i),
        .word_o    (bist_word)
    );

    rx_decision u_decision (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .codes_i     (codes),
        .thresh_i    (thresh_i),
        .sel_bist_i  (sel_bist_i),
        .bist_word_i (bist_word),
        .rx_bits_o   (rx_bits)
    );

    // checker always looks at whatever source the decision stage picked
    prbs_checker u_checker (
        .clk_adc   (clk_adc),
        .reset_i   (reset_i),
        .cfg_i     (prbs_cfg_i),
        .rx_bits_i (rx_bits),
        .counts_o  (counts_o)
    );

    assign bits_o = rx_bits;

endmodule

`default_nettype wire

// ==== tb_dcore.sv ====
`default_nettype none

`include "dcore_settings.svh"

module tb_dcore;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYC  = 5;
    localparam int N_ADC      = 300;
    // the ADC path is two deep, one more word lets the last real entry be checked
    localparam int N_DRAIN    = 3;
    localparam int N_SETTLE   = 3;
    localparam int N_CLEAN    = 20;
    localparam int N_INJ_RUN  = 10;
    localparam int N_MASK     = 20;
    localparam int N_FREEZE   = 10;
    localparam int N_CLEAR    = 2;
    localparam int TOTAL_CYC  = RESET_CYC + N_ADC + N_DRAIN + N_SETTLE + N_CLEAN + 1
                              + N_INJ_RUN + N_MASK + N_FREEZE + N_CLEAR + 1;

    localparam int CODE_MAX = 2 ** (`DCORE_NADC - 1) - 1;
    localparam int CODE_MIN = -(2 ** (`DCORE_NADC - 1));

    // flipped bit plus the two later bits whose prediction uses it
    localparam logic [`DCORE_NTI-1:0] INJ_ERR_MASK = (`DCORE_NTI'(1) << 0)
                                                   | (`DCORE_NTI'(1) << `DCORE_PRBS_TAP_B)
                                                   | (`DCORE_NTI'(1) << `DCORE_PRBS_TAP_A);

    logic                    clk_adc;
    logic                    reset_i;
    dcore_pkg::adc_word_t    adc_i;
    dcore_pkg::offset_word_t offset_i;
    dcore_pkg::code_t        thresh_i;
    logic                    sel_bist_i;
    logic                    gen_cke_i;
    logic                    gen_inj_err_i;
    dcore_pkg::prbs_cfg_t    prbs_cfg_i;
    logic [`DCORE_NTI-1:0]   bits_o;
    dcore_pkg::prbs_counts_t counts_o;

    // expected bits_o words, oldest first
    logic [`DCORE_NTI-1:0]   exp_q [$];
    int                      exp_lat;
    logic                    check_en;
    logic [`DCORE_CNT_W-1:0] exp_err;
    logic [`DCORE_CNT_W-1:0] exp_total;
    logic                    prev_inj;
    // threshold to drive on the next cycle
    dcore_pkg::code_t        thresh_next;
    // software PRBS7, bit i is i+1 serial positions back
    logic [`DCORE_PRBS_ORDER-1:0] prbs_hist;

    dcore_top u_dut (
        .clk_adc       (clk_adc),
        .reset_i       (reset_i),
        .adc_i         (adc_i),
        .offset_i      (offset_i),
        .thresh_i      (thresh_i),
        .sel_bist_i    (sel_bist_i),
        .gen_cke_i     (gen_cke_i),
        .gen_inj_err_i (gen_inj_err_i),
        .prbs_cfg_i    (prbs_cfg_i),
        .bits_o        (bits_o),
        .counts_o      (counts_o)
    );

    initial begin
        clk_adc = 1'b0;
        forever #(CLK_PERIOD / 2) clk_adc = ~clk_adc;
    end

    initial begin
        #((TOTAL_CYC + 100) * CLK_PERIOD);
        $display(">>> FAIL");
        $display("watchdog expired before the test sequence finished");
        $fatal(1, "timeout");
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        $display(">>> FAIL");
        $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp_val, act_val);
        $fatal(1, "wrong value on %s", name);
    endtask

    // signed value of one slice, offset removed and clipped to the code range
    function automatic int unfold_slice(input logic [`DCORE_NADC-1:0] mag, input logic sign,
                                        input dcore_pkg::code_t offset);
        int value;
        value = sign ? int'(mag) : -int'(mag);
        value = value - int'(offset);
        if (value > CODE_MAX) begin
            value = CODE_MAX;
        end else if (value < CODE_MIN) begin
            value = CODE_MIN;
        end
        return value;
    endfunction

    function automatic logic [`DCORE_NTI-1:0] expected_bits(input dcore_pkg::adc_word_t adc,
                                                            input dcore_pkg::offset_word_t off,
                                                            input dcore_pkg::code_t thresh);
        logic [`DCORE_NTI-1:0] word;
        for (int k = 0; k < `DCORE_NTI; k++) begin
            word[k] = (unfold_slice(adc[k].mag, adc[k].sign, off[k]) > int'(thresh));
        end
        return word;
    endfunction

    // next NTI sequence bits, bit 0 first
    function automatic logic [`DCORE_NTI-1:0] prbs_next_word();
        logic [`DCORE_NTI-1:0] word;
        logic                  bit_new;
        for (int k = 0; k < `DCORE_NTI; k++) begin
            bit_new   = prbs_hist[`DCORE_PRBS_TAP_A-1] ^ prbs_hist[`DCORE_PRBS_TAP_B-1];
            word[k]   = bit_new;
            prbs_hist = {prbs_hist[`DCORE_PRBS_ORDER-2:0], bit_new};
        end
        return word;
    endfunction

    // random samples with full-scale magnitudes and extreme offsets mixed in
    task automatic random_adc_inputs();
        int unsigned pick;
        for (int k = 0; k < `DCORE_NTI; k++) begin
            adc_i[k].mag  = `DCORE_NADC'($urandom);
            adc_i[k].sign = 1'($urandom);
            offset_i[k]   = dcore_pkg::code_t'($urandom);
            pick = $urandom % 8;
            case (pick)
                0: adc_i[k].mag = '1;
                1: offset_i[k] = dcore_pkg::code_t'(CODE_MAX);
                2: offset_i[k] = dcore_pkg::code_t'(CODE_MIN);
                3: begin
                    adc_i[k].mag = '1;
                    offset_i[k]  = dcore_pkg::code_t'(adc_i[k].sign ? CODE_MIN : CODE_MAX);
                end
                default: ;
            endcase
        end
        thresh_next = dcore_pkg::code_t'($urandom);
    endtask

    task automatic check_counts();
        assert (counts_o.err_count == exp_err)
            else report_mismatch("counts_o.err_count", exp_err, counts_o.err_count);
        assert (counts_o.total_count == exp_total)
            else report_mismatch("counts_o.total_count", exp_total, counts_o.total_count);
    endtask

    task automatic drive_adc_cycle(input logic new_values);
        @(posedge clk_adc);
        #10;
        // the slicer meets a code one cycle after its ADC word, with the next threshold
        thresh_i = thresh_next;
        if (new_values) begin
            random_adc_inputs();
        end
        sel_bist_i      = 1'b0;
        gen_cke_i       = 1'b0;
        gen_inj_err_i   = 1'b0;
        prbs_cfg_i.mode = dcore_pkg::MODE_CLEAR;
        exp_q.push_back(expected_bits(adc_i, offset_i, thresh_next));
    endtask

    task automatic drive_bist_cycle(input dcore_pkg::checker_mode_e mode,
                                    input logic [`DCORE_NTI-1:0] chan_sel, input logic inj);
        logic [`DCORE_NTI-1:0] word;
        @(posedge clk_adc);
        #10;
        check_counts();
        sel_bist_i          = 1'b1;
        gen_cke_i           = 1'b1;
        gen_inj_err_i       = inj;
        prbs_cfg_i.cke      = 1'b1;
        prbs_cfg_i.chan_sel = chan_sel;
        prbs_cfg_i.mode     = mode;
        word    = prbs_next_word();
        word[0] = word[0] ^ inj;
        exp_q.push_back(word);
        // counters after the coming edge see the word driven one call earlier
        case (mode)
            dcore_pkg::MODE_CLEAR: begin
                exp_err   = '0;
                exp_total = '0;
            end
            dcore_pkg::MODE_COUNT: begin
                exp_total = exp_total + `DCORE_CNT_W'($countones(chan_sel));
                if (prev_inj) begin
                    exp_err = exp_err + `DCORE_CNT_W'($countones(chan_sel & INJ_ERR_MASK));
                end
            end
            default: ;
        endcase
        prev_inj = inj;
    endtask

    // bits_o checked mid-cycle against the word queued exp_lat drives earlier
    always @(negedge clk_adc) begin : compare_bits
        logic [`DCORE_NTI-1:0] exp_word;
        if (check_en && (exp_q.size() > exp_lat)) begin
            exp_word = exp_q.pop_front();
            assert (bits_o == exp_word) else report_mismatch("bits_o", exp_word, bits_o);
        end
    end

    initial begin : stimulus
        logic [`DCORE_NTI-1:0] mask_sel;
        void'($urandom(32'h12f5));
        adc_i         = '0;
        offset_i      = '0;
        thresh_i      = '0;
        thresh_next   = '0;
        sel_bist_i    = 1'b0;
        gen_cke_i     = 1'b0;
        gen_inj_err_i = 1'b0;
        prbs_cfg_i    = '0;
        check_en      = 1'b0;
        exp_lat       = 2;
        exp_err       = '0;
        exp_total     = '0;
        prev_inj      = 1'b0;
        prbs_hist     = '1;
        reset_i       = 1'b1;
        repeat (RESET_CYC) @(posedge clk_adc);
        #10;
        reset_i = 1'b0;
        assert (bits_o == '0) else report_mismatch("bits_o", '0, bits_o);
        check_counts();

        // ADC slicer path
        check_en = 1'b1;
        for (int i = 0; i < N_ADC; i++) begin
            drive_adc_cycle(1'b1);
        end
        repeat (N_DRAIN) drive_adc_cycle(1'b0);

        // BIST path, one register between generator and bits_o
        exp_q.delete();
        exp_lat = 1;
        repeat (N_SETTLE) drive_bist_cycle(dcore_pkg::MODE_CLEAR, '1, 1'b0);
        repeat (N_CLEAN) drive_bist_cycle(dcore_pkg::MODE_COUNT, '1, 1'b0);
        drive_bist_cycle(dcore_pkg::MODE_COUNT, '1, 1'b1);
        repeat (N_INJ_RUN) drive_bist_cycle(dcore_pkg::MODE_COUNT, '1, 1'b0);

        // partial channel mask, then hold and clear
        mask_sel = `DCORE_NTI'($urandom);
        repeat (N_MASK) drive_bist_cycle(dcore_pkg::MODE_COUNT, mask_sel, 1'b0);
        repeat (N_FREEZE) drive_bist_cycle(dcore_pkg::MODE_FREEZE, mask_sel, 1'b0);
        repeat (N_CLEAR) drive_bist_cycle(dcore_pkg::MODE_CLEAR, mask_sel, 1'b0);

        @(posedge clk_adc);
        #10;
        check_counts();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
dcore_pkg.sv
adc_unfold.sv
rx_decision.sv
prbs_gen.sv
prbs_checker.sv
dcore_top.sv
tb_dcore.sv

// ==== Makefile ====
# Verilator build and run for the receive data path testbench

VERILATOR ?= verilator
TOP       ?= tb_dcore
SEED      ?= 4853
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' list.f) dcore_settings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): list.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
